// File: vlog.f
+incdir+src
src/cpu_pkg.sv
src/register_file.sv
src/issue_lane.sv
src/forward_unit.sv
src/dual_issue_core.sv
verification/dual_issue_props.sv
verification/tb_dual_issue.sv

// File: verification/tb_dual_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_dual_issue
  import cpu_pkg::*;
();

  // one issued pair and the cycle its results are due
  typedef struct packed {
    logic [31:0] due;
    wb_t         lane0;
    wb_t         lane1;
  } expect_t;

  logic  clk;
  logic  rst;
  slot_t slot0;
  slot_t slot1;
  wb_t   wb0;
  wb_t   wb1;

  logic [31:0]            rand_state;
  logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
  expect_t                exp_q [$];
  int                     cycle_no;
  int                     errors;
  int                     checks;
  int                     drain_wait;

  dual_issue_core UUT (
    .clk   (clk),
    .rst   (rst),
    .slot0 (slot0),
    .slot1 (slot1),
    .wb0   (wb0),
    .wb1   (wb1)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus generation

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic is_imm_op(input logic [`OPCODE_BITS-1:0] op);
    return (op == `OP_ADDI) || (op == `OP_ANDI) || (op == `OP_ORI);
  endfunction

  function automatic logic [`OPCODE_BITS-1:0] pick_opcode(input logic [31:0] r);
    case (r % 11)
      0: return `OP_ADD;
      1: return `OP_SUB;
      2: return `OP_AND;
      3: return `OP_OR;
      4: return `OP_XOR;
      5: return `OP_SLT;
      6: return `OP_SLL;
      7: return `OP_ADDI;
      8: return `OP_ANDI;
      9: return `OP_ORI;
      // upper half of the opcode space is unused
      default: return {1'b1, r[20:16]};
    endcase
  endfunction

  task automatic make_slot(input int reg_bits, input int bubble_pct, output slot_t s);
    logic [31:0]               r;
    logic [`REG_ADDR_BITS-1:0] mask;
    mask = (1 << reg_bits) - 1;
    s = '0;
    r = next_rand();
    s.valid = ((r >> 8) % 100) >= bubble_pct;
    r = next_rand();
    s.instr.r.opcode = pick_opcode(r >> 8);
    r = next_rand();
    s.instr.r.rs = r[28:24] & mask;
    s.instr.r.rt = r[22:18] & mask;
    r = next_rand();
    s.instr.i.imm = r[31:16];
    if (!is_imm_op(s.instr.r.opcode))
      s.instr.r.rd = r[27:23] & mask;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model applying slots in program order

  function automatic wb_t model_issue(input slot_t s);
    logic [`OPCODE_BITS-1:0]   op;
    logic [`DATA_WIDTH-1:0]    a;
    logic [`DATA_WIDTH-1:0]    b;
    logic [`DATA_WIDTH-1:0]    zimm;
    logic [`DATA_WIDTH-1:0]    result;
    logic [`REG_ADDR_BITS-1:0] dst;
    logic                      known;
    wb_t                       w;
    op     = s.instr.r.opcode;
    a      = model_regs[s.instr.r.rs];
    b      = model_regs[s.instr.r.rt];
    zimm   = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, s.instr.i.imm};
    dst    = s.instr.r.rd;
    known  = 1'b1;
    result = '0;
    case (op)
      `OP_ADD:  result = a + b;
      `OP_SUB:  result = a - b;
      `OP_AND:  result = a & b;
      `OP_OR:   result = a | b;
      `OP_XOR:  result = a ^ b;
      `OP_SLT:  result = ($signed(a) < $signed(b)) ? 1 : 0;
      `OP_SLL:  result = b << s.instr.r.shamt;
      `OP_ADDI: result = a + zimm;
      `OP_ANDI: result = a & zimm;
      `OP_ORI:  result = a | zimm;
      default:  known = 1'b0;
    endcase
    if (is_imm_op(op))
      dst = s.instr.i.rt;
    w = '0;
    if (s.valid && known && dst != '0) begin
      w.valid = 1'b1;
      w.addr  = dst;
      w.data  = result;
      model_regs[dst] = result;
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking and driving

  task automatic check_lane(input int lane, input wb_t got, input wb_t want);
    checks++;
    if (want.valid) begin
      if (!got.valid) begin
        errors++;
        $display("Fail %0t: lane %0d gave no result, expected r%0d = %h",
                 $time, lane, want.addr, want.data);
      end else if (got.addr != want.addr || got.data != want.data) begin
        errors++;
        $display("Fail %0t: lane %0d wrote r%0d = %h, expected r%0d = %h",
                 $time, lane, got.addr, got.data, want.addr, want.data);
      end
    end else if (got.valid) begin
      errors++;
      $display("Fail %0t: lane %0d wrote r%0d = %h, expected no result",
               $time, lane, got.addr, got.data);
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    // nothing due means both lanes must be quiet
    e = '0;
    if (exp_q.size() != 0 && exp_q[0].due == cycle_no)
      e = exp_q.pop_front();
    check_lane(0, wb0, e.lane0);
    check_lane(1, wb1, e.lane1);
  endtask

  task automatic issue_step(input slot_t s0, input slot_t s1, input logic track,
                            input wb_t e0, input wb_t e1);
    expect_t e;
    @(posedge clk);
    #2;
    cycle_no++;
    check_outputs();
    slot0 = s0;
    slot1 = s1;
    if (track) begin
      e.due   = cycle_no + 2;
      e.lane0 = e0;
      e.lane1 = e1;
      exp_q.push_back(e);
    end
  endtask

  task automatic run_random(input int count, input int reg_bits, input int bubble_pct);
    slot_t s0;
    slot_t s1;
    wb_t   e0;
    wb_t   e1;
    for (int i = 0; i < count; i++) begin
      make_slot(reg_bits, bubble_pct, s0);
      e0 = model_issue(s0);
      make_slot(reg_bits, bubble_pct, s1);
      // slot 1 may not read what slot 0 of the same pair writes
      if (e0.valid) begin
        if (s1.instr.r.rs == e0.addr)
          s1.instr.r.rs = s1.instr.r.rs ^ 5'd1;
        if (!is_imm_op(s1.instr.r.opcode) && s1.instr.r.rt == e0.addr)
          s1.instr.r.rt = s1.instr.r.rt ^ 5'd1;
      end
      e1 = model_issue(s1);
      issue_step(s0, s1, 1'b1, e0, e1);
    end
  endtask

  initial begin
    rand_state = 32'h3d6;
    errors     = 0;
    checks     = 0;
    cycle_no   = 0;
    rst        = 1'b1;
    slot0      = '0;
    slot1      = '0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    #2;
    rst = 1'b0;

    // bubbles only and then the full register range
    run_random(8, 5, 100);
    run_random(300, 5, 0);
    // four registers give dense forwarding and same-destination pairs
    run_random(300, 2, 0);
    run_random(2000, 3, 25);

    // drain until the pipeline goes idle
    drain_wait = 0;
    while ((exp_q.size() != 0 || wb0.valid || wb1.valid) && drain_wait < 10) begin
      issue_step('0, '0, 1'b0, '0, '0);
      drain_wait++;
    end
    if (wb0.valid || wb1.valid) begin
      $display("Timeout: write-back still active %0d cycles after the last pair",
               drain_wait);
      $display("Finished with errors");
    end else begin
      issue_step('0, '0, 1'b0, '0, '0);
      errors = errors + UUT.props.violations;
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, UUT.props.violations);
      if (errors == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/dual_issue_props.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_props
  import cpu_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input slot_t slot0,
  input slot_t slot1,
  input wb_t   wb0,
  input wb_t   wb1
);

  int violations = 0;

  wb_low_after_reset: assert property (
    @(posedge clk) rst |=> (!wb0.valid && !wb1.valid)
  ) else begin
    violations++;
    $error("wb valid set in the cycle after reset");
  end

  // r0 writes are dropped at decode
  wb0_addr_nonzero: assert property (
    @(posedge clk) disable iff (rst) wb0.valid |-> (wb0.addr != '0)
  ) else begin
    violations++;
    $error("lane 0 wb valid with address zero");
  end

  wb1_addr_nonzero: assert property (
    @(posedge clk) disable iff (rst) wb1.valid |-> (wb1.addr != '0)
  ) else begin
    violations++;
    $error("lane 1 wb valid with address zero");
  end

  wb0_from_valid_slot: assert property (
    @(posedge clk) disable iff (rst) wb0.valid |-> $past(slot0.valid, 2)
  ) else begin
    violations++;
    $error("lane 0 wb valid without a valid slot two cycles earlier");
  end

  wb1_from_valid_slot: assert property (
    @(posedge clk) disable iff (rst) wb1.valid |-> $past(slot1.valid, 2)
  ) else begin
    violations++;
    $error("lane 1 wb valid without a valid slot two cycles earlier");
  end

endmodule

bind dual_issue_core dual_issue_props props (
  .clk   (clk),
  .rst   (rst),
  .slot0 (slot0),
  .slot1 (slot1),
  .wb0   (wb0),
  .wb1   (wb1)
);

`default_nettype wire

// File: src/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module dual_issue_core
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  slot_t slot0,
  input  slot_t slot1,
  output wb_t   wb0,
  output wb_t   wb1
);

  logic [`REG_ADDR_BITS-1:0] rs0;
  logic [`REG_ADDR_BITS-1:0] rt0;
  logic [`REG_ADDR_BITS-1:0] rs1;
  logic [`REG_ADDR_BITS-1:0] rt1;
  logic [`DATA_WIDTH-1:0]    rd_data_a0;
  logic [`DATA_WIDTH-1:0]    rd_data_b0;
  logic [`DATA_WIDTH-1:0]    rd_data_a1;
  logic [`DATA_WIDTH-1:0]    rd_data_b1;

  // execute stage sources and their forwarding selects
  logic [`REG_ADDR_BITS-1:0] ex_rs0;
  logic [`REG_ADDR_BITS-1:0] ex_rt0;
  logic [`REG_ADDR_BITS-1:0] ex_rs1;
  logic [`REG_ADDR_BITS-1:0] ex_rt1;
  fwd_sel_t                  sel_a0;
  fwd_sel_t                  sel_b0;
  fwd_sel_t                  sel_a1;
  fwd_sel_t                  sel_b1;

  ////////////////////////////////////////////////////////////////////////////
  // lanes

  issue_lane lane0 (
    .clk       (clk),
    .rst       (rst),
    .slot      (slot0),
    .rs        (rs0),
    .rt        (rt0),
    .rd_data_a (rd_data_a0),
    .rd_data_b (rd_data_b0),
    .ex_rs     (ex_rs0),
    .ex_rt     (ex_rt0),
    .sel_a     (sel_a0),
    .sel_b     (sel_b0),
    .fwd0      (wb0),
    .fwd1      (wb1),
    .wb        (wb0)
  );

  issue_lane lane1 (
    .clk       (clk),
    .rst       (rst),
    .slot      (slot1),
    .rs        (rs1),
    .rt        (rt1),
    .rd_data_a (rd_data_a1),
    .rd_data_b (rd_data_b1),
    .ex_rs     (ex_rs1),
    .ex_rt     (ex_rt1),
    .sel_a     (sel_a1),
    .sel_b     (sel_b1),
    .fwd0      (wb0),
    .fwd1      (wb1),
    .wb        (wb1)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shared regfile and forwarding

  register_file regs (
    .clk        (clk),
    .rst        (rst),
    .rd_addr_a0 (rs0),
    .rd_addr_b0 (rt0),
    .rd_addr_a1 (rs1),
    .rd_addr_b1 (rt1),
    .rd_data_a0 (rd_data_a0),
    .rd_data_b0 (rd_data_b0),
    .rd_data_a1 (rd_data_a1),
    .rd_data_b1 (rd_data_b1),
    .wr0        (wb0),
    .wr1        (wb1)
  );

  forward_unit fwd (
    .ex_rs0 (ex_rs0),
    .ex_rt0 (ex_rt0),
    .ex_rs1 (ex_rs1),
    .ex_rt1 (ex_rt1),
    .wb0    (wb0),
    .wb1    (wb1),
    .sel_a0 (sel_a0),
    .sel_b0 (sel_b0),
    .sel_a1 (sel_a1),
    .sel_b1 (sel_b1)
  );

endmodule

`default_nettype wire

// File: src/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module forward_unit
  import cpu_pkg::*;
(
  input  logic [`REG_ADDR_BITS-1:0] ex_rs0,
  input  logic [`REG_ADDR_BITS-1:0] ex_rt0,
  input  logic [`REG_ADDR_BITS-1:0] ex_rs1,
  input  logic [`REG_ADDR_BITS-1:0] ex_rt1,
  input  wb_t                       wb0,
  input  wb_t                       wb1,
  output fwd_sel_t                  sel_a0,
  output fwd_sel_t                  sel_b0,
  output fwd_sel_t                  sel_a1,
  output fwd_sel_t                  sel_b1
);

  // only EX/WB is a source, older results are already in the regfile
  function automatic fwd_sel_t pick_source(
    input logic [`REG_ADDR_BITS-1:0] src,
    input wb_t                       w0,
    input wb_t                       w1
  );
    fwd_sel_t sel;
    sel = from_reg;
    if (src != '0) begin
      // lane 1 is younger, so check it first
      if (w1.valid && w1.addr == src)
        sel = from_lane1;
      else if (w0.valid && w0.addr == src)
        sel = from_lane0;
    end
    return sel;
  endfunction

  // lane 0 operands
  assign sel_a0 = pick_source(ex_rs0, wb0, wb1);
  assign sel_b0 = pick_source(ex_rt0, wb0, wb1);

  // lane 1 operands
  assign sel_a1 = pick_source(ex_rs1, wb0, wb1);
  assign sel_b1 = pick_source(ex_rt1, wb0, wb1);

endmodule

`default_nettype wire

// File: src/issue_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module issue_lane
  import cpu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  slot_t                     slot,
  output logic [`REG_ADDR_BITS-1:0] rs,
  output logic [`REG_ADDR_BITS-1:0] rt,
  input  logic [`DATA_WIDTH-1:0]    rd_data_a,
  input  logic [`DATA_WIDTH-1:0]    rd_data_b,
  output logic [`REG_ADDR_BITS-1:0] ex_rs,
  output logic [`REG_ADDR_BITS-1:0] ex_rt,
  input  fwd_sel_t                  sel_a,
  input  fwd_sel_t                  sel_b,
  input  wb_t                       fwd0,
  input  wb_t                       fwd1,
  output wb_t                       wb
);

  ctrl_t                     ctrl;
  logic                      known;

  ctrl_t                     idex_ctrl;
  logic [`REG_ADDR_BITS-1:0] idex_rs;
  logic [`REG_ADDR_BITS-1:0] idex_rt;
  logic [`DATA_WIDTH-1:0]    idex_a;
  logic [`DATA_WIDTH-1:0]    idex_b;

  logic [`DATA_WIDTH-1:0]    op_a;
  logic [`DATA_WIDTH-1:0]    op_b_reg;
  logic [`DATA_WIDTH-1:0]    op_b;
  logic [`DATA_WIDTH-1:0]    alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // decode

  // rs and rt sit in the same bits in both formats
  assign rs = slot.instr.r.rs;
  assign rt = slot.instr.r.rt;

  always_comb begin
    ctrl        = '0;
    known       = 1'b1;
    ctrl.imm    = slot.instr.i.imm;
    ctrl.shamt  = slot.instr.r.shamt;
    ctrl.dst    = slot.instr.r.rd;
    ctrl.alu_op = alu_add;
    case (slot.instr.r.opcode)
      `OP_ADD: ctrl.alu_op = alu_add;
      `OP_SUB: ctrl.alu_op = alu_sub;
      `OP_AND: ctrl.alu_op = alu_and;
      `OP_OR:  ctrl.alu_op = alu_or;
      `OP_XOR: ctrl.alu_op = alu_xor;
      `OP_SLT: ctrl.alu_op = alu_slt;
      `OP_SLL: ctrl.alu_op = alu_sll;
      `OP_ADDI, `OP_ANDI, `OP_ORI: begin
        ctrl.use_imm = 1'b1;
        ctrl.dst     = slot.instr.i.rt;
        if (slot.instr.i.opcode == `OP_ANDI)
          ctrl.alu_op = alu_and;
        else if (slot.instr.i.opcode == `OP_ORI)
          ctrl.alu_op = alu_or;
      end
      default: known = 1'b0;
    endcase
    // writes to r0 are dropped here, so no later stage sees them
    ctrl.reg_write = slot.valid && known && (ctrl.dst != '0);
  end

  // ID/EX
  always_ff @(posedge clk) begin
    if (rst) begin
      idex_ctrl.reg_write <= 1'b0;
    end else begin
      idex_ctrl <= ctrl;
      idex_rs   <= rs;
      idex_rt   <= rt;
      idex_a    <= rd_data_a;
      idex_b    <= rd_data_b;
    end
  end

  assign ex_rs = idex_rs;
  assign ex_rt = idex_rt;

  ////////////////////////////////////////////////////////////////////////////
  // execute

  always_comb begin
    case (sel_a)
      from_lane0: op_a = fwd0.data;
      from_lane1: op_a = fwd1.data;
      default:    op_a = idex_a;
    endcase
    case (sel_b)
      from_lane0: op_b_reg = fwd0.data;
      from_lane1: op_b_reg = fwd1.data;
      default:    op_b_reg = idex_b;
    endcase
  end

  // zero-extended immediate
  assign op_b = idex_ctrl.use_imm ?
                {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, idex_ctrl.imm} : op_b_reg;

  always_comb begin
    case (idex_ctrl.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(`DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sll: alu_result = op_b << idex_ctrl.shamt;
      default: alu_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= idex_ctrl.reg_write;
      wb.addr  <= idex_ctrl.dst;
      wb.data  <= alu_result;
    end
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module register_file
  import cpu_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr_a0,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr_b0,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr_a1,
  input  logic [`REG_ADDR_BITS-1:0] rd_addr_b1,
  output logic [`DATA_WIDTH-1:0]    rd_data_a0,
  output logic [`DATA_WIDTH-1:0]    rd_data_b0,
  output logic [`DATA_WIDTH-1:0]    rd_data_a1,
  output logic [`DATA_WIDTH-1:0]    rd_data_b1,
  input  wb_t                       wr0,
  input  wb_t                       wr1
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

  // read with bypass from both write ports, lane 1 last so it wins
  function automatic logic [`DATA_WIDTH-1:0] read_port(
    input logic [`REG_ADDR_BITS-1:0] addr,
    input logic [`DATA_WIDTH-1:0]    stored,
    input wb_t                       w0,
    input wb_t                       w1
  );
    logic [`DATA_WIDTH-1:0] value;
    value = stored;
    if (w0.valid && w0.addr == addr)
      value = w0.data;
    if (w1.valid && w1.addr == addr)
      value = w1.data;
    // r0 reads zero whatever is on the write ports
    if (addr == '0)
      value = '0;
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0.valid && wr0.addr != '0)
        regs[wr0.addr] <= wr0.data;
      // same address from both lanes, younger one lands
      if (wr1.valid && wr1.addr != '0)
        regs[wr1.addr] <= wr1.data;
    end
  end

  assign rd_data_a0 = read_port(rd_addr_a0, regs[rd_addr_a0], wr0, wr1);
  assign rd_data_b0 = read_port(rd_addr_b0, regs[rd_addr_b0], wr0, wr1);
  assign rd_data_a1 = read_port(rd_addr_a1, regs[rd_addr_a1], wr0, wr1);
  assign rd_data_b1 = read_port(rd_addr_b1, regs[rd_addr_b1], wr0, wr1);

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  `include "cpu_settings.svh"

  // r format, also used for shifts
  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`SHAMT_BITS-1:0]    shamt;
    logic [5:0]                spare;
  } r_fmt_t;

  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`IMM_WIDTH-1:0]     imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_t;

  // one issue slot
  typedef struct packed {
    logic   valid;
    instr_t instr;
  } slot_t;

  typedef struct packed {
    logic                      reg_write;
    logic                      use_imm;
    alu_op_t                   alu_op;
    logic [`REG_ADDR_BITS-1:0] dst;
    logic [`SHAMT_BITS-1:0]    shamt;
    logic [`IMM_WIDTH-1:0]     imm;
  } ctrl_t;

  // write-back result, also the EX/WB contents
  typedef struct packed {
    logic                      valid;
    logic [`REG_ADDR_BITS-1:0] addr;
    logic [`DATA_WIDTH-1:0]    data;
  } wb_t;

  typedef enum logic [1:0] {
    from_reg,
    from_lane0,
    from_lane1
  } fwd_sel_t;

endpackage

`default_nettype wire

// File: src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH     32
`define INST_WIDTH     32
`define IMM_WIDTH      16

// register file
`define NUM_REGS       32
`define REG_ADDR_BITS  5

// instruction fields
`define SHAMT_BITS     5
`define OPCODE_BITS    6

// r-type opcodes
`define OP_ADD         6'h01
`define OP_SUB         6'h02
`define OP_AND         6'h03
`define OP_OR          6'h04
`define OP_XOR         6'h05
`define OP_SLT         6'h06
`define OP_SLL         6'h07

// immediate opcodes, imm is zero-extended
`define OP_ADDI        6'h08
`define OP_ANDI        6'h09
`define OP_ORI         6'h0a

`endif
